// ==== dv/alpha_control_checker.sv ====
module alpha_control_checker import alpha_serial_pkg::*; #(
	parameter int STEP_CYCLES = 4,
	parameter int TOKEN_WAIT_STEPS = 6,
	parameter int PICKOFF = 6
) (
	input logic clock,
	input logic reset,
	input logic start_button,
	input logic load_req,
	input config_word_t load_word,
	input logic load_ack,
	input logic dreset,
	input logic sync,
	input logic tok_a_f2t,
	input logic trig_top,
	input logic sin,
	input logic sclk,
	output int error_count,
	output int check_count
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LOAD_END = (PHASES_PER_BIT * TOTAL_BITS + 1) * STEP_CYCLES; // ack seen from here
	localparam int TOKEN2_STEP = 8 + TOKEN_WAIT_STEPS; // step of the second token
	localparam int IDX_BITS = $clog2(CONFIG_BITS);

	localparam logic [1:0] L_IDLE = 2'd0;
	localparam logic [1:0] L_SHIFT = 2'd1;
	localparam logic [1:0] L_ACK = 2'd2;

	int sample_n; // posedges since reset
	int prog_t; // cycles since outputs cleared, -1 before any press
	int start_due[$]; // samples where pending presses clear the outputs
	logic button_prev;
	logic [1:0] load_state; // model of the loader handshake
	int load_t; // cycles into the current load
	config_word_t word_m; // word the host handed over
	logic [TOTAL_BITS-1:0] rebuilt; // sin taken at each sclk rise
	int sclk_edges;
	logic load_clean; // no chip reset during this load
	logic sclk_prev;

	// program step n covers cycles n*STEP_CYCLES up to the next step
	function automatic logic in_step(input int t, input int n);
		return (t >= n * STEP_CYCLES) && (t < (n + 1) * STEP_CYCLES);
	endfunction

	// data bit k set at step 1+3k, word lsb first, zeros past the word
	function automatic logic load_sin(input int t, input config_word_t w);
		int s;
		int k;
		logic [IDX_BITS-1:0] idx;
		s = t / STEP_CYCLES;
		k = (s - 1) / PHASES_PER_BIT;
		idx = k[IDX_BITS-1:0];
		if (s < 1 || k >= CONFIG_BITS) begin
			return 1'b0;
		end
		return w[idx];
	endfunction

	function automatic logic load_clk(input int t);
		int s;
		s = t / STEP_CYCLES;
		return (s >= 1) && ((s - 1) % PHASES_PER_BIT == 1); // middle phase of a bit
	endfunction

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error %s: expected %0b, actual %0b at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic compare_value(input string name, input int expected, input int actual);
		check_count++;
		if (actual != expected) begin
			error_count++;
			$display("error %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	always @(posedge clock) begin : model
		logic e_dreset;
		logic e_sin;
		logic e_clk;
		if (reset) begin
			error_count = 0;
			check_count = 0;
			sample_n = 0;
			prog_t = -1; // nothing pressed yet
			start_due.delete();
			button_prev = 1'b0;
			load_state = L_IDLE;
			load_t = 0;
			sclk_prev = 1'b0;
		end else begin
			e_dreset = in_step(prog_t, 1);
			e_sin = (load_state == L_SHIFT) ? load_sin(load_t, word_m) : 1'b0;
			e_clk = (load_state == L_SHIFT) ? load_clk(load_t) : 1'b0;
			compare_bit("seq_dreset", e_dreset, dreset);
			compare_bit("seq_sync", in_step(prog_t, 3), sync);
			compare_bit("seq_token", in_step(prog_t, 5) || in_step(prog_t, TOKEN2_STEP), tok_a_f2t);
			compare_bit("seq_trig", in_step(prog_t, 7), trig_top);
			compare_bit("load_sin", e_sin, sin);
			compare_bit("load_sclk", e_clk | e_dreset, sclk); // chip reset forces sclk
			compare_bit("load_ack", load_state == L_ACK, load_ack);

			// rising sclk during a load, data must already sit on sin
			if (load_state == L_SHIFT) begin
				if (e_dreset) load_clean = 1'b0; // extra edges from chip reset
				if (sclk && !sclk_prev) begin
					rebuilt = {sin, rebuilt[TOTAL_BITS-1:1]};
					sclk_edges++;
				end
			end

			// press seen here clears the outputs PICKOFF+1 samples later
			if (start_button && !button_prev) start_due.push_back(sample_n + PICKOFF + 1);
			if (start_due.size() > 0 && start_due[0] == sample_n + 1) begin
				void'(start_due.pop_front());
				prog_t = 0;
			end else if (prog_t >= 0) begin
				prog_t++;
			end

			case (load_state)
				L_IDLE: begin
					if (load_req) begin // taken on the first cycle seen
						word_m = load_word;
						load_t = 0;
						rebuilt = '0;
						sclk_edges = 0;
						load_clean = 1'b1;
						load_state = L_SHIFT;
					end
				end
				L_SHIFT: begin
					if (load_t + 1 == LOAD_END) begin
						if (load_clean) begin
							compare_value("load_clock_count", TOTAL_BITS, sclk_edges);
							compare_value("load_rebuild", int'({{DUMMY_BITS{1'b0}}, word_m}),
								int'(rebuilt));
						end
						load_state = L_ACK;
					end else begin
						load_t++;
					end
				end
				default: begin
					if (!load_req) load_state = L_IDLE; // ack drops one cycle later
				end
			endcase

			button_prev = start_button;
			sclk_prev = sclk;
			sample_n++;
		end
	end

endmodule

// ==== dv/alpha_control_tb.sv ====
module alpha_control_tb import alpha_serial_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int STEP_CYCLES = 4;
	localparam int TOKEN_WAIT_STEPS = 6;
	localparam int PICKOFF = 6;
	localparam logic [31:0] SEED = 32'h1309_6adb;
	localparam int LOADS = 12; // host words sent
	localparam int PRESSES = 6; // button presses, odd ones land mid-sequence
	localparam int SEQ_CYCLES = (10 + TOKEN_WAIT_STEPS) * STEP_CYCLES; // whole program
	localparam int ACK_TIMEOUT = (PHASES_PER_BIT * TOTAL_BITS + 4) * STEP_CYCLES + 50;

	logic clock = 1'b0;
	logic reset;
	logic start_button;
	logic load_req;
	config_word_t load_word;
	logic load_ack;
	logic dreset;
	logic sync;
	logic tok_a_f2t;
	logic trig_top;
	logic sin;
	logic sclk;
	int error_count;
	int check_count;
	int timeout_count;

	always #4 clock = ~clock; // 8 ns period

	alpha_control_top #(
		.STEP_CYCLES(STEP_CYCLES),
		.TOKEN_WAIT_STEPS(TOKEN_WAIT_STEPS),
		.PICKOFF(PICKOFF)
	) UUT (
		.clock(clock),
		.reset(reset),
		.start_button(start_button),
		.load_req(load_req),
		.load_word(load_word),
		.load_ack(load_ack),
		.dreset(dreset),
		.sync(sync),
		.tok_a_f2t(tok_a_f2t),
		.trig_top(trig_top),
		.sin(sin),
		.sclk(sclk)
	);

	alpha_control_checker #(
		.STEP_CYCLES(STEP_CYCLES),
		.TOKEN_WAIT_STEPS(TOKEN_WAIT_STEPS),
		.PICKOFF(PICKOFF)
	) checks (
		.clock(clock),
		.reset(reset),
		.start_button(start_button),
		.load_req(load_req),
		.load_word(load_word),
		.load_ack(load_ack),
		.dreset(dreset),
		.sync(sync),
		.tok_a_f2t(tok_a_f2t),
		.trig_top(trig_top),
		.sin(sin),
		.sclk(sclk),
		.error_count(error_count),
		.check_count(check_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int pick(input logic [31:0] r, input int lo, input int hi);
		return lo + (int'(r[30:16]) % (hi - lo + 1)); // upper bits, low ones cycle fast
	endfunction

	// at least one edge, then until load_ack reaches level
	task automatic wait_for_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (load_ack !== level && cycles < ACK_TIMEOUT);
		if (load_ack !== level) begin
			timeout_count++;
			$display("timeout: load_ack did not %s within %0d cycles", what, ACK_TIMEOUT);
		end
	endtask

	task automatic run_host();
		logic [31:0] rng;
		int n;
		int hold;
		rng = SEED;
		for (n = 0; n < LOADS; n++) begin
			rng = lcg_next(rng);
			load_word <= config_word_t'(rng[31:16]);
			load_req <= 1'b1;
			wait_for_ack(1'b1, "rise");
			rng = lcg_next(rng);
			hold = pick(rng, 0, 5); // extra cycles before release
			repeat (hold) @(posedge clock);
			load_req <= 1'b0;
			rng = lcg_next(rng);
			if (n < LOADS - 1 && rng[9:8] == 2'b00) begin
				@(posedge clock); // next request while ack is still high
			end else begin
				wait_for_ack(1'b0, "fall");
				rng = lcg_next(rng);
				repeat (pick(rng, 0, 12)) @(posedge clock);
			end
		end
	endtask

	task automatic run_button();
		logic [31:0] rng;
		int n;
		int gap;
		rng = lcg_next(SEED ^ 32'h0000_ffff); // own stream, same seed
		for (n = 0; n < PRESSES; n++) begin
			rng = lcg_next(rng);
			if (n % 2 == 1) gap = pick(rng, 20, 50); // restart mid-sequence
			else gap = pick(rng, SEQ_CYCLES + 16, SEQ_CYCLES + 50);
			repeat (gap) @(posedge clock);
			start_button <= 1'b1;
			rng = lcg_next(rng);
			repeat (pick(rng, 1, 8)) @(posedge clock);
			start_button <= 1'b0;
		end
		repeat (SEQ_CYCLES + PICKOFF + 8) @(posedge clock); // last program runs out
	endtask

	initial begin
		reset = 1'b1;
		start_button = 1'b0;
		load_req = 1'b0;
		load_word = '0;
		timeout_count = 0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		repeat (20) @(posedge clock); // quiet outputs before any stimulus
		fork
			run_button();
			run_host();
		join
		repeat (4) @(posedge clock);
		$display("checks %0d, value errors %0d, timeouts %0d",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
src/alpha_timing_pkg.sv
src/alpha_serial_pkg.sv
src/step_timer.sv
src/startup_sequencer.sv
src/serial_loader.sv
src/alpha_control_top.sv
dv/alpha_control_checker.sv
dv/alpha_control_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the alpha control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module alpha_control_tb -Mdir "$OBJ" -f filelist.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$OBJ/Valpha_control_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides pass or fail
if grep -qx "Finished with no errors" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== src/alpha_control_top.sv ====
module alpha_control_top import alpha_timing_pkg::*, alpha_serial_pkg::*; #(
	parameter integer STEP_CYCLES = STEP_CYCLES_DEFAULT,
	parameter integer TOKEN_WAIT_STEPS = TOKEN_WAIT_STEPS_DEFAULT,
	parameter integer PICKOFF = PICKOFF_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic start_button,
	input logic load_req,
	input config_word_t load_word,
	output logic load_ack,
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic trig_top,
	output logic sin,
	output logic sclk
);

	step_index_t seq_step; // startup program step
	logic seq_restart;
	logic seq_run;
	logic seq_tick;
	step_index_t load_step; // serial load step
	logic load_restart;
	logic load_run;
	logic load_tick;

	step_timer #(.STEP_CYCLES(STEP_CYCLES)) seq_timer (
		.clock(clock),
		.reset(reset),
		.restart(seq_restart),
		.run(seq_run),
		.step(seq_step),
		.tick(seq_tick)
	);

	startup_sequencer #(
		.PICKOFF(PICKOFF),
		.TOKEN_WAIT_STEPS(TOKEN_WAIT_STEPS)
	) sequencer (
		.clock(clock),
		.reset(reset),
		.start_button(start_button),
		.step(seq_step),
		.tick(seq_tick),
		.restart(seq_restart),
		.run(seq_run),
		.dreset(dreset), // also forces sclk in the loader
		.sync(sync),
		.tok_a_f2t(tok_a_f2t),
		.trig_top(trig_top)
	);

	step_timer #(.STEP_CYCLES(STEP_CYCLES)) load_timer (
		.clock(clock),
		.reset(reset),
		.restart(load_restart),
		.run(load_run),
		.step(load_step),
		.tick(load_tick)
	);

	serial_loader loader (
		.clock(clock),
		.reset(reset),
		.load_req(load_req),
		.load_word(load_word),
		.load_ack(load_ack),
		.dreset(dreset),
		.step(load_step),
		.tick(load_tick),
		.restart(load_restart),
		.run(load_run),
		.sin(sin),
		.sclk(sclk)
	);

endmodule

// ==== src/alpha_serial_pkg.sv ====
package alpha_serial_pkg;

	localparam int CONFIG_BITS = 16; // config word width
	localparam int DUMMY_BITS = 4; // zeros clocked after the word
	localparam int TOTAL_BITS = CONFIG_BITS + DUMMY_BITS; // bits per load
	localparam int PHASES_PER_BIT = 3; // steps per bit

	typedef logic [CONFIG_BITS-1:0] config_word_t; // host config word
	typedef logic [4:0] bit_index_t; // bit position, dummies included
	typedef logic [1:0] phase_t; // phase inside one bit

	// bit phases, in the order they run
	localparam phase_t PHASE_DATA = 2'd0; // sin takes the bit
	localparam phase_t PHASE_HIGH = 2'd1; // sclk high, chip samples sin
	localparam phase_t PHASE_LOW = 2'd2; // sclk low again

	// one bit occupies PHASES_PER_BIT steps,
	// so the whole load spans PHASES_PER_BIT*TOTAL_BITS steps after idle step 0

endpackage

// ==== src/alpha_timing_pkg.sv ====
package alpha_timing_pkg;

	// default step timing, overridden from the top
	localparam integer STEP_CYCLES_DEFAULT = 100; // clock cycles per step
	localparam integer TOKEN_WAIT_STEPS_DEFAULT = 1121; // steps from trig_top end to second token
	localparam integer PICKOFF_DEFAULT = 6; // button pipeline depth

	typedef logic [15:0] step_index_t; // step number since a restart
	typedef logic [15:0] cycle_count_t; // cycle count inside one step

	// startup program steps, step 0 is idle
	localparam step_index_t STEP_DRESET = 16'd1; // chip reset high
	localparam step_index_t STEP_SYNC = 16'd3; // sync high
	localparam step_index_t STEP_TOKEN = 16'd5; // first token high
	localparam step_index_t STEP_TRIG = 16'd7; // trig_top high
	localparam step_index_t STEP_WAIT = 16'd8; // start of the long wait

	// even steps between the pulses drop the previous output
	// second token and end step follow STEP_WAIT by the wait length

endpackage

// ==== src/serial_loader.sv ====
module serial_loader import alpha_timing_pkg::*, alpha_serial_pkg::*; (
	input logic clock,
	input logic reset,
	input logic load_req, // four-phase request from host
	input config_word_t load_word, // stable while load_req high
	output logic load_ack,
	input logic dreset, // chip reset from the sequencer
	input step_index_t step, // from the step timer
	input logic tick,
	output logic restart, // to step timer
	output logic run,
	output logic sin, // serial data to chip
	output logic sclk // serial clock to chip
);

	localparam logic [1:0] ST_IDLE = 2'd0; // waiting for load_req
	localparam logic [1:0] ST_SHIFT = 2'd1; // bits going out
	localparam logic [1:0] ST_ACK = 2'd2; // ack high until req drops

	// last clock-low step of the last dummy bit
	localparam step_index_t LAST_STEP = step_index_t'(PHASES_PER_BIT * TOTAL_BITS);
	localparam int WORD_SEL_BITS = $clog2(CONFIG_BITS);

	logic [1:0] state;
	config_word_t word_q; // latched host word
	logic sclk_int; // clock before the dreset override
	logic take_req; // request accepted this cycle
	bit_index_t next_bit; // bit of the step about to start
	phase_t next_phase;

	// step s >= 1 belongs to bit (s-1)/3, so the next step s+1 maps from s
	assign next_bit = bit_index_t'(step / PHASES_PER_BIT);
	assign next_phase = phase_t'(step % PHASES_PER_BIT);

	assign take_req = (state == ST_IDLE) && load_req; // ack is low in idle
	assign restart = take_req;
	assign run = (state == ST_SHIFT);

	assign sclk = sclk_int | dreset; // chip reset holds sclk high

	always_ff @(posedge clock) begin
		if (take_req) begin
			word_q <= load_word; // first cycle req seen while idle
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			load_ack <= 1'b0;
			sin <= 1'b0;
			sclk_int <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (take_req) begin
						state <= ST_SHIFT; // timer at step 0 next cycle
					end
				end
				ST_SHIFT: begin
					if (tick) begin
						if (step == LAST_STEP) begin
							state <= ST_ACK; // last clock-low step over
							load_ack <= 1'b1;
						end else begin
							case (next_phase)
								PHASE_DATA: begin
									// lsb first, zeros past the word
									if (next_bit < bit_index_t'(CONFIG_BITS)) begin
										sin <= word_q[next_bit[WORD_SEL_BITS-1:0]];
									end else begin
										sin <= 1'b0;
									end
								end
								PHASE_HIGH: sclk_int <= 1'b1;
								PHASE_LOW: sclk_int <= 1'b0;
								default: sclk_int <= 1'b0;
							endcase
						end
					end
				end
				ST_ACK: begin
					if (!load_req) begin // host released, close handshake
						state <= ST_IDLE;
						load_ack <= 1'b0;
					end
				end
				default: begin
					state <= ST_IDLE;
					load_ack <= 1'b0;
				end
			endcase
		end
	end

	// host must still hold its request when the ack comes up
	a_ack_with_req: assert property (
		@(posedge clock) disable iff (reset)
		$rose(load_ack) |-> load_req
	);

	// chip samples sin during sclk high
	a_sin_stable: assert property (
		@(posedge clock) disable iff (reset)
		sclk_int |-> $stable(sin)
	);

endmodule

// ==== src/startup_sequencer.sv ====
module startup_sequencer import alpha_timing_pkg::*; #(
	parameter integer PICKOFF = PICKOFF_DEFAULT,
	parameter integer TOKEN_WAIT_STEPS = TOKEN_WAIT_STEPS_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic start_button, // raw level from the board
	input step_index_t step, // from the step timer
	input logic tick,
	output logic restart, // to step timer
	output logic run,
	output logic dreset, // chip reset
	output logic sync,
	output logic tok_a_f2t,
	output logic trig_top
);

	// second token after the long wait, then one low step, then done
	localparam step_index_t TOKEN2_STEP = step_index_t'(STEP_WAIT + TOKEN_WAIT_STEPS);
	localparam step_index_t END_STEP = step_index_t'(STEP_WAIT + TOKEN_WAIT_STEPS + 2);

	logic [PICKOFF:0] button_pipe; // bit 0 newest
	logic start_edge; // old low, new high at the pickoff taps
	logic running; // program active
	step_index_t next_step; // step that starts after this tick

	assign start_edge = (button_pipe[PICKOFF:PICKOFF-1] == 2'b01);
	assign restart = start_edge; // timer is at step 0 the next cycle
	assign run = running;
	assign next_step = step + 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			button_pipe <= '0;
			running <= 1'b0;
			dreset <= 1'b0;
			sync <= 1'b0;
			tok_a_f2t <= 1'b0;
			trig_top <= 1'b0;
		end else begin
			button_pipe <= {button_pipe[PICKOFF-1:0], start_button}; // shift in
			if (start_edge) begin
				// a new press restarts from step 0 with everything low
				running <= 1'b1;
				dreset <= 1'b0;
				sync <= 1'b0;
				tok_a_f2t <= 1'b0;
				trig_top <= 1'b0;
			end else if (running && tick) begin
				// outputs set for the step about to begin,
				// so they change on the same edge as the step number
				dreset <= (next_step == STEP_DRESET);
				sync <= (next_step == STEP_SYNC);
				tok_a_f2t <= (next_step == STEP_TOKEN) || (next_step == TOKEN2_STEP);
				trig_top <= (next_step == STEP_TRIG); // drops at STEP_WAIT
				if (next_step == END_STEP) begin
					running <= 1'b0; // timer holds from here
				end
			end
		end
	end

	// startup pulses are sequential, never overlapping
	a_one_pulse: assert property (
		@(posedge clock) disable iff (reset)
		$onehot0({dreset, sync, trig_top})
	);

endmodule

// ==== src/step_timer.sv ====
module step_timer import alpha_timing_pkg::*; #(
	parameter integer STEP_CYCLES = STEP_CYCLES_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic restart, // back to step 0, count 0
	input logic run, // count when high, hold when low
	output step_index_t step,
	output logic tick // last cycle of a step
);

	localparam cycle_count_t LAST_COUNT = cycle_count_t'(STEP_CYCLES - 1);

	cycle_count_t count; // cycles into current step

	// tick only while running, a held timer does not repeat it
	assign tick = run && (count == LAST_COUNT);

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			step <= '0;
		end else if (restart) begin // restart wins over run
			count <= '0;
			step <= '0;
		end else if (run) begin
			if (tick) begin
				count <= '0; // wrap
				step <= step + 1'b1; // next step starts
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// wrap has to happen before the count leaves the step,
	// otherwise the step number would stall for a full counter lap
	a_count_in_step: assert property (
		@(posedge clock) disable iff (reset)
		count < cycle_count_t'(STEP_CYCLES)
	);

endmodule
